/* common/dcache_pkg.sv */
////////////////////////////////////////
// Shared widths, vector types and enums
// for the replay D$ harness
////////////////////////////////////////

package dcache_pkg;

   localparam int paddr_width       = 32;
   localparam int page_offset_width = 12;
   localparam int ptag_width        = 20;

   // Page offset is index, double-word select and byte offset
   localparam int index_width       = 7;
   localparam int dword_sel_width   = 2;
   localparam int byte_offset_width = 3;

   localparam int dword_width       = 64;
   localparam int block_width       = 256;

   typedef logic [ptag_width-1:0]        ptag_t;
   typedef logic [page_offset_width-1:0] page_offset_t;
   typedef logic [index_width-1:0]       index_t;
   typedef logic [dword_width-1:0]       dword_t;
   typedef logic [block_width-1:0]       block_t;
   typedef logic [paddr_width-1:0]       paddr_t;

   typedef enum logic [1:0]
   {
      e_mem_block_read,
      e_mem_uc_read,
      e_mem_write
   } mem_op_e;

   typedef enum logic [1:0]
   {
      e_idle,
      e_send,
      e_wait,
      e_fill
   } miss_state_e;

endpackage

/* rtl/replay_fifo.sv */
////////////////////////////////////////
// Request FIFO with rollback; entries
// free on commit, roll rewinds the head
////////////////////////////////////////

`timescale 1ns/1ns

module replay_fifo
  #(parameter int replay_els_p = 8)
   ( input  logic                     clk_i
   , input  logic                     rst_i

   , input  logic                     enq_v_i
   , input  logic                     enq_store_i
   , input  dcache_pkg::page_offset_t enq_offset_i
   , input  dcache_pkg::dword_t       enq_data_i
   , input  dcache_pkg::ptag_t        enq_ptag_i
   , input  logic                     enq_uncached_i
   , output logic                     ready_o

   , output logic                     head_v_o
   , output logic                     head_store_o
   , output dcache_pkg::page_offset_t head_offset_o
   , output dcache_pkg::dword_t       head_data_o
   , output dcache_pkg::ptag_t        head_ptag_o
   , output logic                     head_uncached_o

   , input  logic                     yumi_i
   , input  logic                     commit_i
   , input  logic                     roll_i
   );

   localparam int addr_width_lp = $clog2(replay_els_p);
   localparam int ptr_width_lp  = addr_width_lp + 1;

   logic                     store_mem    [replay_els_p];
   dcache_pkg::page_offset_t offset_mem   [replay_els_p];
   dcache_pkg::dword_t       data_mem     [replay_els_p];
   dcache_pkg::ptag_t        ptag_mem     [replay_els_p];
   logic                     uncached_mem [replay_els_p];

   logic [ptr_width_lp-1:0]  wptr_r, rptr_r, cptr_r;
   logic [ptr_width_lp-1:0]  used;
   logic [addr_width_lp-1:0] waddr, raddr;
   logic                     enq;

   // Occupancy counts from the commit pointer, not the read pointer
   assign used    = wptr_r - cptr_r;
   assign ready_o = (used != ptr_width_lp'(replay_els_p));
   assign enq     = enq_v_i & ready_o;

   assign waddr = wptr_r[addr_width_lp-1:0];
   assign raddr = rptr_r[addr_width_lp-1:0];

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         store_mem[waddr]    <= enq_store_i;
         offset_mem[waddr]   <= enq_offset_i;
         data_mem[waddr]     <= enq_data_i;
         ptag_mem[waddr]     <= enq_ptag_i;
         uncached_mem[waddr] <= enq_uncached_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wptr_r <= '0;
         rptr_r <= '0;
         cptr_r <= '0;
      end
      else
      begin
         if (enq)
            wptr_r <= wptr_r + 1'b1;
         // Rewind wins over a same-cycle dequeue
         if (roll_i)
            rptr_r <= cptr_r;
         else if (yumi_i)
            rptr_r <= rptr_r + 1'b1;
         if (commit_i)
            cptr_r <= cptr_r + 1'b1;
      end
   end

   assign head_v_o        = (rptr_r != wptr_r);
   assign head_store_o    = store_mem[raddr];
   assign head_offset_o   = offset_mem[raddr];
   assign head_data_o     = data_mem[raddr];
   assign head_ptag_o     = ptag_mem[raddr];
   assign head_uncached_o = uncached_mem[raddr];

   // Read pointer stays between the commit and write pointers
   a_rptr_window: assert property (@(posedge clk_i) disable iff (rst_i)
      ptr_width_lp'(rptr_r - cptr_r) <= used);

   // Completion must belong to a request already handed to the cache
   a_commit_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
      commit_i |-> (rptr_r != cptr_r));

endmodule

/* dcache/dcache_pipe.sv */
////////////////////////////////////////
// Two-stage direct-mapped D$ lookup with
// write-through stores and poison/roll
////////////////////////////////////////

`timescale 1ns/1ns

module dcache_pipe
   ( input  logic                     clk_i
   , input  logic                     rst_i

   , input  logic                     req_v_i
   , input  logic                     req_store_i
   , input  dcache_pkg::page_offset_t req_offset_i
   , input  dcache_pkg::dword_t       req_data_i
   , input  dcache_pkg::ptag_t        req_ptag_i
   , input  logic                     req_uncached_i
   , output logic                     ready_o

   , output logic                     v_o
   , output dcache_pkg::dword_t       data_o
   , output logic                     roll_o

   , output logic                     miss_v_o
   , output logic                     miss_uncached_o
   , output dcache_pkg::paddr_t       miss_paddr_o

   , output logic                     st_v_o
   , output dcache_pkg::paddr_t       st_paddr_o
   , output dcache_pkg::dword_t       st_data_o
   , input  logic                     st_ready_i

   , input  logic                     fill_v_i
   , input  dcache_pkg::index_t       fill_index_i
   , input  dcache_pkg::ptag_t        fill_tag_i
   , input  dcache_pkg::block_t       fill_block_i

   , input  logic                     uc_v_i
   , input  dcache_pkg::dword_t       uc_data_i
   , output logic                     uc_yumi_o

   , input  logic                     busy_i
   );

   localparam int num_sets_lp     = 2 ** dcache_pkg::index_width;
   localparam int block_dwords_lp = 2 ** dcache_pkg::dword_sel_width;
   localparam int sel_lsb_lp      = dcache_pkg::byte_offset_width;
   localparam int index_lsb_lp    = sel_lsb_lp + dcache_pkg::dword_sel_width;

   dcache_pkg::ptag_t  tag_mem  [num_sets_lp];
   dcache_pkg::dword_t data_mem [num_sets_lp][block_dwords_lp];
   logic [num_sets_lp-1:0] valid_r;

   logic                     s1_v_r, s1_store_r, s1_uncached_r;
   dcache_pkg::page_offset_t s1_offset_r;
   dcache_pkg::dword_t       s1_data_r;
   dcache_pkg::ptag_t        s1_ptag_r;
   dcache_pkg::index_t       s1_index;
   logic [dcache_pkg::dword_sel_width-1:0] s1_dsel;

   logic                     s2_v_r, s2_store_r, s2_uncached_r, s2_valid_r;
   dcache_pkg::index_t       s2_index_r;
   logic [dcache_pkg::dword_sel_width-1:0] s2_dsel_r;
   dcache_pkg::dword_t       s2_data_r, s2_word_r;
   dcache_pkg::ptag_t        s2_ptag_r, s2_tag_r;
   dcache_pkg::paddr_t       s2_paddr;

   logic accept, tag_hit, load_hit, uc_done, st_done, st_hit;

   // No new requests while a miss is out or a fill is landing
   assign ready_o = ~busy_i & ~fill_v_i;
   assign accept  = req_v_i & ready_o;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         s1_v_r <= 1'b0;
         s2_v_r <= 1'b0;
      end
      else
      begin
         s1_v_r <= accept & ~roll_o;
         s2_v_r <= s1_v_r & ~roll_o;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         s1_store_r    <= req_store_i;
         s1_offset_r   <= req_offset_i;
         s1_data_r     <= req_data_i;
         s1_ptag_r     <= req_ptag_i;
         s1_uncached_r <= req_uncached_i;
      end
   end

   assign s1_index = s1_offset_r[index_lsb_lp +: dcache_pkg::index_width];
   assign s1_dsel  = s1_offset_r[sel_lsb_lp +: dcache_pkg::dword_sel_width];

   // Array read in stage 1, registered into stage 2
   always_ff @(posedge clk_i)
   begin
      s2_store_r    <= s1_store_r;
      s2_uncached_r <= s1_uncached_r;
      s2_index_r    <= s1_index;
      s2_dsel_r     <= s1_dsel;
      s2_data_r     <= s1_data_r;
      s2_ptag_r     <= s1_ptag_r;
      s2_tag_r      <= tag_mem[s1_index];
      s2_valid_r    <= valid_r[s1_index];
      // Forward a store hit landing in the same cycle
      if (st_hit && (s2_index_r == s1_index) && (s2_dsel_r == s1_dsel))
         s2_word_r <= s2_data_r;
      else
         s2_word_r <= data_mem[s1_index][s1_dsel];
   end

   assign tag_hit  = s2_valid_r & (s2_tag_r == s2_ptag_r);
   assign load_hit = s2_v_r & ~s2_store_r & ~s2_uncached_r & tag_hit;
   assign uc_done  = s2_v_r & ~s2_store_r & s2_uncached_r & uc_v_i;
   assign st_done  = s2_v_r & s2_store_r & st_ready_i;
   assign st_hit   = st_done & tag_hit;

   assign v_o    = load_hit | uc_done | st_done;
   assign roll_o = s2_v_r & ~v_o;
   assign data_o = s2_store_r ? '0 : (s2_uncached_r ? uc_data_i : s2_word_r);

   assign s2_paddr = {s2_ptag_r, s2_index_r, s2_dsel_r,
                      dcache_pkg::byte_offset_width'(0)};

   // Poisoned loads start the miss engine; poisoned stores just retry
   assign miss_v_o        = roll_o & ~s2_store_r & ~busy_i;
   assign miss_uncached_o = s2_uncached_r;
   assign miss_paddr_o    = s2_paddr;

   assign st_v_o     = s2_v_r & s2_store_r;
   assign st_paddr_o = s2_paddr;
   assign st_data_o  = s2_data_r;
   assign uc_yumi_o  = uc_done;

   always_ff @(posedge clk_i)
   begin
      if (fill_v_i)
      begin
         tag_mem[fill_index_i] <= fill_tag_i;
         for (int i = 0; i < block_dwords_lp; i++)
            data_mem[fill_index_i][i]
               <= fill_block_i[i*dcache_pkg::dword_width +: dcache_pkg::dword_width];
      end
      else if (st_hit)
         data_mem[s2_index_r][s2_dsel_r] <= s2_data_r;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         valid_r <= '0;
      else if (fill_v_i)
         valid_r[fill_index_i] <= 1'b1;
   end

   // A poisoned load always finds the miss engine free
   a_miss_engine_free: assert property (@(posedge clk_i) disable iff (rst_i)
      (roll_o && !s2_store_r) |-> (!busy_i && !fill_v_i));

endmodule

/* dcache/dcache_miss_engine.sv */
////////////////////////////////////////
// Memory-side FSM: block fills, uncached
// reads, one-entry write-through buffer
////////////////////////////////////////

`timescale 1ns/1ns

module dcache_miss_engine
   ( input  logic                  clk_i
   , input  logic                  rst_i

   , input  logic                  miss_v_i
   , input  logic                  miss_uncached_i
   , input  dcache_pkg::paddr_t    miss_paddr_i
   , output logic                  busy_o

   , input  logic                  st_v_i
   , input  dcache_pkg::paddr_t    st_paddr_i
   , input  dcache_pkg::dword_t    st_data_i
   , output logic                  st_ready_o

   , output logic                  fill_v_o
   , output dcache_pkg::index_t    fill_index_o
   , output dcache_pkg::ptag_t     fill_tag_o
   , output dcache_pkg::block_t    fill_block_o

   , output logic                  uc_v_o
   , output dcache_pkg::dword_t    uc_data_o
   , input  logic                  uc_yumi_i

   , output logic                  mem_cmd_v_o
   , output dcache_pkg::mem_op_e   mem_cmd_op_o
   , output dcache_pkg::paddr_t    mem_cmd_addr_o
   , output dcache_pkg::dword_t    mem_cmd_data_o
   , input  logic                  mem_cmd_ready_and_i

   , input  logic                  mem_resp_v_i
   , input  dcache_pkg::block_t    mem_resp_data_i
   , output logic                  mem_resp_yumi_o
   );

   localparam int block_offset_lp = dcache_pkg::dword_sel_width
                                  + dcache_pkg::byte_offset_width;

   dcache_pkg::miss_state_e state_r, state_n;
   logic                    miss_uncached_r;
   dcache_pkg::paddr_t      miss_paddr_r, block_paddr;
   dcache_pkg::block_t      block_r;
   logic                    wb_v_r, uc_v_r;
   dcache_pkg::paddr_t      wb_paddr_r;
   dcache_pkg::dword_t      wb_data_r, uc_data_r;
   logic [dcache_pkg::dword_sel_width-1:0] uc_sel;
   logic                    read_sent, resp_fire;

   // Pending write always goes first, keeping reads behind stores
   assign read_sent = (state_r == dcache_pkg::e_send) & ~wb_v_r & mem_cmd_ready_and_i;
   assign resp_fire = (state_r == dcache_pkg::e_wait) & mem_resp_v_i;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         dcache_pkg::e_idle:
            if (miss_v_i)
               state_n = dcache_pkg::e_send;
         dcache_pkg::e_send:
            if (read_sent)
               state_n = dcache_pkg::e_wait;
         dcache_pkg::e_wait:
            if (resp_fire)
               state_n = miss_uncached_r ? dcache_pkg::e_idle : dcache_pkg::e_fill;
         default:
            state_n = dcache_pkg::e_idle;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r <= dcache_pkg::e_idle;
         wb_v_r  <= 1'b0;
         uc_v_r  <= 1'b0;
      end
      else
      begin
         state_r <= state_n;
         if (st_v_i && st_ready_o)
            wb_v_r <= 1'b1;
         else if (wb_v_r && mem_cmd_ready_and_i)
            wb_v_r <= 1'b0;
         if (resp_fire && miss_uncached_r)
            uc_v_r <= 1'b1;
         else if (uc_yumi_i)
            uc_v_r <= 1'b0;
      end
   end

   assign uc_sel = miss_paddr_r[dcache_pkg::byte_offset_width +: dcache_pkg::dword_sel_width];

   always_ff @(posedge clk_i)
   begin
      if (miss_v_i && (state_r == dcache_pkg::e_idle))
      begin
         miss_uncached_r <= miss_uncached_i;
         miss_paddr_r    <= miss_paddr_i;
      end
      if (st_v_i && st_ready_o)
      begin
         wb_paddr_r <= st_paddr_i;
         wb_data_r  <= st_data_i;
      end
      if (resp_fire)
      begin
         block_r   <= mem_resp_data_i;
         uc_data_r <= mem_resp_data_i[uc_sel*dcache_pkg::dword_width +: dcache_pkg::dword_width];
      end
   end

   assign block_paddr = {miss_paddr_r[dcache_pkg::paddr_width-1:block_offset_lp],
                         block_offset_lp'(0)};

   assign mem_cmd_v_o    = wb_v_r | (state_r == dcache_pkg::e_send);
   assign mem_cmd_op_o   = wb_v_r ? dcache_pkg::e_mem_write
                         : (miss_uncached_r ? dcache_pkg::e_mem_uc_read
                                            : dcache_pkg::e_mem_block_read);
   assign mem_cmd_addr_o = wb_v_r ? wb_paddr_r
                         : (miss_uncached_r ? miss_paddr_r : block_paddr);
   assign mem_cmd_data_o = wb_v_r ? wb_data_r : '0;
   assign mem_resp_yumi_o = resp_fire;

   assign busy_o     = (state_r == dcache_pkg::e_send) | (state_r == dcache_pkg::e_wait);
   assign st_ready_o = ~wb_v_r;

   assign fill_v_o     = (state_r == dcache_pkg::e_fill);
   assign fill_index_o = miss_paddr_r[block_offset_lp +: dcache_pkg::index_width];
   assign fill_tag_o   = miss_paddr_r[dcache_pkg::paddr_width-1 -: dcache_pkg::ptag_width];
   assign fill_block_o = block_r;

   assign uc_v_o    = uc_v_r;
   assign uc_data_o = uc_data_r;

   a_cmd_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_cmd_v_o && !mem_cmd_ready_and_i |=> mem_cmd_v_o
         && $stable(mem_cmd_op_o) && $stable(mem_cmd_addr_o) && $stable(mem_cmd_data_o));

endmodule

/* rtl/dcache_harness.sv */
////////////////////////////////////////
// Top level: replay FIFO feeding the D$
// pipeline and its miss engine
////////////////////////////////////////

`timescale 1ns/1ns

module dcache_harness
  #(parameter int replay_els_p = 8)
   ( input  logic                     clk_i
   , input  logic                     rst_i

   , input  logic                     req_v_i
   , input  logic                     req_store_i
   , input  dcache_pkg::page_offset_t req_offset_i
   , input  dcache_pkg::dword_t       req_data_i
   , input  dcache_pkg::ptag_t        ptag_i
   , input  logic                     uncached_i
   , output logic                     ready_o

   , output logic                     v_o
   , output dcache_pkg::dword_t       data_o

   , output logic                     mem_cmd_v_o
   , output dcache_pkg::mem_op_e      mem_cmd_op_o
   , output dcache_pkg::paddr_t       mem_cmd_addr_o
   , output dcache_pkg::dword_t       mem_cmd_data_o
   , input  logic                     mem_cmd_ready_and_i

   , input  logic                     mem_resp_v_i
   , input  dcache_pkg::block_t       mem_resp_data_i
   , output logic                     mem_resp_yumi_o
   );

   logic                     fifo_v, fifo_store, fifo_uncached;
   dcache_pkg::page_offset_t fifo_offset;
   dcache_pkg::dword_t       fifo_data;
   dcache_pkg::ptag_t        fifo_ptag;
   logic                     pipe_ready, fifo_yumi, roll;

   logic                     miss_v, miss_uncached, busy;
   dcache_pkg::paddr_t       miss_paddr, st_paddr;
   logic                     st_v, st_ready;
   dcache_pkg::dword_t       st_data, uc_data;
   logic                     fill_v, uc_v, uc_yumi;
   dcache_pkg::index_t       fill_index;
   dcache_pkg::ptag_t        fill_tag;
   dcache_pkg::block_t       fill_block;

   assign fifo_yumi = fifo_v & pipe_ready;

   replay_fifo
    #(.replay_els_p(replay_els_p))
    fifo_i
     (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.enq_v_i(req_v_i)
     ,.enq_store_i(req_store_i)
     ,.enq_offset_i(req_offset_i)
     ,.enq_data_i(req_data_i)
     ,.enq_ptag_i(ptag_i)
     ,.enq_uncached_i(uncached_i)
     ,.ready_o(ready_o)
     ,.head_v_o(fifo_v)
     ,.head_store_o(fifo_store)
     ,.head_offset_o(fifo_offset)
     ,.head_data_o(fifo_data)
     ,.head_ptag_o(fifo_ptag)
     ,.head_uncached_o(fifo_uncached)
     ,.yumi_i(fifo_yumi)
     ,.commit_i(v_o)
     ,.roll_i(roll)
     );

   dcache_pipe
    pipe_i
     (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.req_v_i(fifo_v)
     ,.req_store_i(fifo_store)
     ,.req_offset_i(fifo_offset)
     ,.req_data_i(fifo_data)
     ,.req_ptag_i(fifo_ptag)
     ,.req_uncached_i(fifo_uncached)
     ,.ready_o(pipe_ready)
     ,.v_o(v_o)
     ,.data_o(data_o)
     ,.roll_o(roll)
     ,.miss_v_o(miss_v)
     ,.miss_uncached_o(miss_uncached)
     ,.miss_paddr_o(miss_paddr)
     ,.st_v_o(st_v)
     ,.st_paddr_o(st_paddr)
     ,.st_data_o(st_data)
     ,.st_ready_i(st_ready)
     ,.fill_v_i(fill_v)
     ,.fill_index_i(fill_index)
     ,.fill_tag_i(fill_tag)
     ,.fill_block_i(fill_block)
     ,.uc_v_i(uc_v)
     ,.uc_data_i(uc_data)
     ,.uc_yumi_o(uc_yumi)
     ,.busy_i(busy)
     );

   dcache_miss_engine
    miss_i
     (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.miss_v_i(miss_v)
     ,.miss_uncached_i(miss_uncached)
     ,.miss_paddr_i(miss_paddr)
     ,.busy_o(busy)
     ,.st_v_i(st_v)
     ,.st_paddr_i(st_paddr)
     ,.st_data_i(st_data)
     ,.st_ready_o(st_ready)
     ,.fill_v_o(fill_v)
     ,.fill_index_o(fill_index)
     ,.fill_tag_o(fill_tag)
     ,.fill_block_o(fill_block)
     ,.uc_v_o(uc_v)
     ,.uc_data_o(uc_data)
     ,.uc_yumi_i(uc_yumi)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_op_o(mem_cmd_op_o)
     ,.mem_cmd_addr_o(mem_cmd_addr_o)
     ,.mem_cmd_data_o(mem_cmd_data_o)
     ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_data_i(mem_resp_data_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     );

endmodule

/* dv/tb_mem_model.sv */
////////////////////////////////////////
// Behavioral memory for the D$ testbench
// Random command stall, random read delay
////////////////////////////////////////

`timescale 1ns/1ns

module tb_mem_model
   ( input  logic                clk_i
   , input  logic                rst_i

   , input  logic                cmd_v_i
   , input  dcache_pkg::mem_op_e cmd_op_i
   , input  dcache_pkg::paddr_t  cmd_addr_i
   , input  dcache_pkg::dword_t  cmd_data_i
   , output logic                cmd_ready_and_o

   , output logic                resp_v_o
   , output dcache_pkg::block_t  resp_data_o
   , input  logic                resp_yumi_i
   );

   localparam int words_lp = 512;

   dcache_pkg::dword_t mem_r [words_lp];
   logic               pend_r;
   dcache_pkg::paddr_t line_r;
   int unsigned        delay_r;

   // Address pool keeps bit 11 clear, so 4 KB holds both tags
   function automatic int unsigned word_index(input dcache_pkg::paddr_t addr);
      return {addr[12], addr[10:3]};
   endfunction

   function automatic dcache_pkg::block_t read_block(input dcache_pkg::paddr_t addr);
      dcache_pkg::block_t blk;
      int unsigned        base;
      base = word_index(addr) & ~32'h3;
      for (int k = 0; k < 4; k++)
         blk[k*dcache_pkg::dword_width +: dcache_pkg::dword_width] = mem_r[base + k];
      return blk;
   endfunction

   initial
   begin
      for (int i = 0; i < words_lp; i++)
         mem_r[i] = {32'h5eed_0000 ^ 32'(i), ~(32'(i) * 32'h0001_0003)};
      cmd_ready_and_o = 1'b0;
      resp_v_o        = 1'b0;
      resp_data_o     = '0;
      pend_r          = 1'b0;
      line_r          = '0;
      delay_r         = 0;
   end

   always @(posedge clk_i)
   begin
      if (rst_i)
         pend_r <= 1'b0;
      else
      begin
         if (cmd_v_i && cmd_ready_and_o)
         begin
            if (cmd_op_i == dcache_pkg::e_mem_write)
               mem_r[word_index(cmd_addr_i)] <= cmd_data_i;
            else
            begin
               pend_r <= 1'b1;
               line_r <= cmd_addr_i;
            end
         end
         if (resp_v_o && resp_yumi_i)
            pend_r <= 1'b0;
      end
   end

   always @(negedge clk_i)
   begin
      // Bursty back-pressure on commands
      cmd_ready_and_o <= ~rst_i & ($urandom_range(0, 3) != 0);
      if (!pend_r)
      begin
         resp_v_o <= 1'b0;
         delay_r  <= $urandom_range(0, 7);
      end
      else if (!resp_v_o)
      begin
         if (delay_r == 0)
         begin
            resp_v_o    <= 1'b1;
            resp_data_o <= read_block(line_r);
         end
         else
            delay_r <= delay_r - 1;
      end
   end

endmodule

/* dv/tb_dcache_harness.sv */
////////////////////////////////////////
// Random load/store traffic through the
// D$ harness against an in-order model
////////////////////////////////////////

`timescale 1ns/1ns

module tb_dcache_harness;

   localparam int replay_els_lp  = 8;
   localparam int num_reqs_lp    = 600;
   localparam int wait_limit_lp  = 500;
   localparam int drain_limit_lp = 5000;
   localparam int kind_load_lp   = 0;
   localparam int kind_uc_lp     = 1;
   localparam int kind_store_lp  = 2;

   logic                     clk;
   logic                     rst;
   logic                     req_v, req_store, uncached;
   dcache_pkg::page_offset_t req_offset;
   dcache_pkg::dword_t       req_data;
   dcache_pkg::ptag_t        ptag;
   logic                     ready, v;
   dcache_pkg::dword_t       data;
   logic                     mem_cmd_v, mem_cmd_ready_and;
   dcache_pkg::mem_op_e      mem_cmd_op;
   dcache_pkg::paddr_t       mem_cmd_addr;
   dcache_pkg::dword_t       mem_cmd_data;
   logic                     mem_resp_v, mem_resp_yumi;
   dcache_pkg::block_t       mem_resp_data;

   dcache_pkg::dword_t model_mem [512];
   dcache_pkg::dword_t exp_data_q [$];
   int                 exp_kind_q [$];
   dcache_pkg::paddr_t exp_addr_q [$];
   dcache_pkg::paddr_t wr_addr_q [$];
   dcache_pkg::dword_t wr_data_q [$];
   dcache_pkg::paddr_t uc_addr_q [$];
   // Line each set holds after its latest block read
   dcache_pkg::paddr_t resident_line [bit [6:0]];
   int                 accepted_count = 0;
   int                 completed_count = 0;
   bit                 full_seen = 1'b0;

   initial clk = 1'b0;
   always #50 clk = ~clk;

   dcache_harness
    #(.replay_els_p(replay_els_lp))
    dcache_harness_i
     (.clk_i(clk)
     ,.rst_i(rst)
     ,.req_v_i(req_v)
     ,.req_store_i(req_store)
     ,.req_offset_i(req_offset)
     ,.req_data_i(req_data)
     ,.ptag_i(ptag)
     ,.uncached_i(uncached)
     ,.ready_o(ready)
     ,.v_o(v)
     ,.data_o(data)
     ,.mem_cmd_v_o(mem_cmd_v)
     ,.mem_cmd_op_o(mem_cmd_op)
     ,.mem_cmd_addr_o(mem_cmd_addr)
     ,.mem_cmd_data_o(mem_cmd_data)
     ,.mem_cmd_ready_and_i(mem_cmd_ready_and)
     ,.mem_resp_v_i(mem_resp_v)
     ,.mem_resp_data_i(mem_resp_data)
     ,.mem_resp_yumi_o(mem_resp_yumi)
     );

   tb_mem_model
    mem_model_i
     (.clk_i(clk)
     ,.rst_i(rst)
     ,.cmd_v_i(mem_cmd_v)
     ,.cmd_op_i(mem_cmd_op)
     ,.cmd_addr_i(mem_cmd_addr)
     ,.cmd_data_i(mem_cmd_data)
     ,.cmd_ready_and_o(mem_cmd_ready_and)
     ,.resp_v_o(mem_resp_v)
     ,.resp_data_o(mem_resp_data)
     ,.resp_yumi_i(mem_resp_yumi)
     );

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_mismatch(input string what);
      stop_with_failure($sformatf("mismatch at %0t ns: %s", $time, what));
   endtask

   function automatic int unsigned word_index(input dcache_pkg::paddr_t addr);
      return {addr[12], addr[10:3]};
   endfunction

   task automatic check_idle_outputs();
      assert (!v && !mem_cmd_v && !mem_resp_yumi && ready)
         else report_mismatch($sformatf("idle outputs v_o=%b cmd_v=%b yumi=%b ready_o=%b",
                                        v, mem_cmd_v, mem_resp_yumi, ready));
   endtask

   task automatic send_request();
      int                                     waited;
      dcache_pkg::index_t                     index;
      logic [dcache_pkg::dword_sel_width-1:0] dsel;
      index      = dcache_pkg::index_t'($urandom_range(0, 7));
      dsel       = 2'($urandom_range(0, 3));
      req_v      = 1'b1;
      req_store  = ($urandom_range(0, 2) == 0);
      uncached   = ($urandom_range(0, 7) == 0);
      ptag       = dcache_pkg::ptag_t'($urandom_range(0, 1));
      req_offset = {index, dsel, 3'b000};
      req_data   = {$urandom, $urandom};
      waited     = 0;
      while (!ready)
      begin
         @(negedge clk);
         waited++;
         if (waited > wait_limit_lp)
            stop_with_failure("timeout: the FIFO never accepted a request");
      end
      @(negedge clk);
   endtask

   task automatic accept_request();
      dcache_pkg::paddr_t addr;
      int unsigned        idx;
      addr = {ptag, req_offset};
      idx  = word_index(addr);
      exp_addr_q.push_back(addr);
      if (req_store)
      begin
         model_mem[idx] = req_data;
         exp_data_q.push_back(dcache_pkg::dword_t'(0));
         exp_kind_q.push_back(kind_store_lp);
         wr_addr_q.push_back(addr);
         wr_data_q.push_back(req_data);
      end
      else
      begin
         exp_data_q.push_back(model_mem[idx]);
         exp_kind_q.push_back(uncached ? kind_uc_lp : kind_load_lp);
      end
      accepted_count++;
   endtask

   task automatic check_completion();
      dcache_pkg::dword_t exp;
      int                 kind;
      dcache_pkg::paddr_t addr;
      dcache_pkg::paddr_t line;
      bit [6:0]           set;
      assert (exp_data_q.size() != 0)
         else report_mismatch("v_o pulsed with no request outstanding");
      exp  = exp_data_q.pop_front();
      kind = exp_kind_q.pop_front();
      addr = exp_addr_q.pop_front();
      line = {addr[31:5], 5'b0};
      set  = addr[11:5];
      assert (data === exp)
         else report_mismatch($sformatf("request %0d at %h returned %h, expected %h",
                                        completed_count, addr, data, exp));
      if (kind == kind_load_lp)
      begin
         assert (resident_line.exists(set) && resident_line[set] == line)
            else report_mismatch($sformatf("cached load %h hit without a block read of %h",
                                           addr, line));
      end
      else if (kind == kind_uc_lp)
      begin
         assert (uc_addr_q.size() != 0 && uc_addr_q[0] == addr)
            else report_mismatch($sformatf("uncached load %h had no matching uc read", addr));
         void'(uc_addr_q.pop_front());
      end
      completed_count++;
   endtask

   task automatic check_mem_command();
      case (mem_cmd_op)
         dcache_pkg::e_mem_write:
         begin
            assert (wr_addr_q.size() != 0)
               else report_mismatch("memory write with no store pending");
            assert (mem_cmd_addr == wr_addr_q[0] && mem_cmd_data == wr_data_q[0])
               else report_mismatch($sformatf("write %h/%h, expected %h/%h", mem_cmd_addr,
                                              mem_cmd_data, wr_addr_q[0], wr_data_q[0]));
            void'(wr_addr_q.pop_front());
            void'(wr_data_q.pop_front());
         end
         dcache_pkg::e_mem_uc_read:
            uc_addr_q.push_back(mem_cmd_addr);
         dcache_pkg::e_mem_block_read:
         begin
            assert (mem_cmd_addr[4:0] == 5'b0)
               else report_mismatch($sformatf("unaligned block read %h", mem_cmd_addr));
            resident_line[mem_cmd_addr[11:5]] = mem_cmd_addr;
         end
         default:
            report_mismatch($sformatf("unknown memory opcode %0d", mem_cmd_op));
      endcase
   endtask

   always @(posedge clk)
   begin
      if (rst)
      begin
         // Reference memory starts from the model's fill pattern
         for (int i = 0; i < 512; i++)
            model_mem[i] = mem_model_i.mem_r[i];
      end
      else
      begin
         assert (ready == ((accepted_count - completed_count) < replay_els_lp))
            else report_mismatch($sformatf("ready_o=%b with %0d requests outstanding",
                                           ready, accepted_count - completed_count));
         if (!ready)
            full_seen = 1'b1;
         if (v)
            check_completion();
         if (mem_cmd_v && mem_cmd_ready_and)
            check_mem_command();
         if (req_v && ready)
            accept_request();
      end
   end

   initial
   begin
      int waited;
      void'($urandom(15084));
      rst        = 1'b1;
      req_v      = 1'b0;
      req_store  = 1'b0;
      req_offset = '0;
      req_data   = '0;
      ptag       = '0;
      uncached   = 1'b0;
      repeat (10)
      begin
         @(negedge clk);
         check_idle_outputs();
      end
      rst = 1'b0;
      repeat (3)
      begin
         @(negedge clk);
         check_idle_outputs();
      end

      for (int n = 0; n < num_reqs_lp; n++)
      begin
         // Occasional gap between bursts
         if ($urandom_range(0, 15) == 0)
         begin
            req_v = 1'b0;
            repeat ($urandom_range(1, 24)) @(negedge clk);
         end
         send_request();
      end
      req_v = 1'b0;

      waited = 0;
      while ((completed_count != accepted_count) || (wr_addr_q.size() != 0))
      begin
         @(negedge clk);
         waited++;
         if (waited > drain_limit_lp)
            stop_with_failure("timeout: requests or writes still outstanding at end of run");
      end
      assert (exp_data_q.size() == 0 && uc_addr_q.size() == 0)
         else report_mismatch("expected results left over after all requests completed");

      if (!full_seen)
         stop_with_failure("the FIFO never filled, so ready_o back-pressure went unchecked");
      else
      begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

/* verilog.f */
common/dcache_pkg.sv
rtl/replay_fifo.sv
dcache/dcache_pipe.sv
dcache/dcache_miss_engine.sv
rtl/dcache_harness.sv
dv/tb_mem_model.sv
dv/tb_dcache_harness.sv

/* Bender.yml */
package:
  name: dcache_harness

sources:
  # Design
  - common/dcache_pkg.sv
  - rtl/replay_fifo.sv
  - dcache/dcache_pipe.sv
  - dcache/dcache_miss_engine.sv
  - rtl/dcache_harness.sv

  # Testbench
  - target: test
    files:
      - dv/tb_mem_model.sv
      - dv/tb_dcache_harness.sv
